// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  core_pkg::alu_op_t          op,
	input  logic [core_pkg::XLEN-1:0]  a,
	input  logic [core_pkg::XLEN-1:0]  b,
	output logic [core_pkg::XLEN-1:0]  result,
	output logic                       zero
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0]; // rv32 shifts use 5 bits

	always_comb begin
		case (op)
			alu_add,
			alu_pc_add: result = a + b;
			alu_sub:    result = a - b;
			alu_sll:    result = a << shamt;
			alu_slt:    result = XLEN'($signed(a) < $signed(b));
			alu_sltu:   result = XLEN'(a < b);
			alu_xor:    result = a ^ b;
			alu_srl:    result = a >> shamt;
			alu_sra:    result = $unsigned($signed(a) >>> shamt);
			alu_or:     result = a | b;
			alu_and:    result = a & b;
			default:    result = '0; // alu_none
		endcase
	end

	assign zero = (result == '0); // beq/bne after sub

endmodule

`default_nettype wire

// ==== logic/alu_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode (
	input  logic [6:0]         opcode,
	input  logic [2:0]         funct3,
	input  logic               funct7_b5,
	output core_pkg::alu_op_t  alu_op
);
	import core_pkg::*;

	always_comb begin
		alu_op = alu_none; // unknown opcodes
		case (opcode)
			opc_lui:   alu_op = alu_add;    // 0 + imm_u
			opc_auipc: alu_op = alu_pc_add;
			opc_jal:   alu_op = alu_pc_add; // link = pc + 4
			opc_jalr:  alu_op = alu_pc_add;
			opc_branch: begin
				case (funct3)
					3'b000, 3'b001: alu_op = alu_sub;  // beq, bne on zero flag
					3'b100, 3'b101: alu_op = alu_slt;  // blt, bge
					3'b110, 3'b111: alu_op = alu_sltu; // bltu, bgeu
					default:        alu_op = alu_none;
				endcase
			end
			opc_load:  alu_op = alu_add; // address generation
			opc_store: alu_op = alu_add;
			opc_op_imm: begin
				case (funct3)
					3'b000: alu_op = alu_add;  // addi, no subi
					3'b010: alu_op = alu_slt;  // slti is a signed compare
					3'b011: alu_op = alu_sltu;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					3'b001: alu_op = alu_sll;
					3'b101: alu_op = funct7_b5 ? alu_sra : alu_srl; // srai vs srli
					default: alu_op = alu_none;
				endcase
			end
			opc_op: begin
				case (funct3)
					3'b000: alu_op = funct7_b5 ? alu_sub : alu_add;
					3'b001: alu_op = alu_sll;
					3'b010: alu_op = alu_slt;
					3'b011: alu_op = alu_sltu;
					3'b100: alu_op = alu_xor;
					3'b101: alu_op = funct7_b5 ? alu_sra : alu_srl;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: alu_op = alu_none;
				endcase
			end
			opc_fence:  alu_op = alu_and; // no-op, result unused
			opc_system: alu_op = alu_and;
			default:    alu_op = alu_none;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run,
	input  logic [core_pkg::XLEN-1:0]  instr,
	input  logic                       fetch_done,
	output logic                       fetch_start,
	output logic [core_pkg::XLEN-1:0]  pc,
	input  core_pkg::alu_op_t          alu_op,
	output logic [core_pkg::XLEN-1:0]  alu_a,
	output logic [core_pkg::XLEN-1:0]  alu_b,
	input  logic [core_pkg::XLEN-1:0]  alu_result,
	input  logic                       alu_zero,
	input  logic [core_pkg::XLEN-1:0]  rs1_data,
	input  logic [core_pkg::XLEN-1:0]  rs2_data,
	output logic                       rf_we,
	output logic [4:0]                 rf_wa,
	output logic [core_pkg::XLEN-1:0]  rf_wd,
	output logic                       lsu_start,
	output logic                       lsu_we,
	output logic [core_pkg::XLEN-1:0]  lsu_addr,
	output logic [core_pkg::XLEN-1:0]  lsu_wdata,
	input  logic                       lsu_done,
	input  logic [core_pkg::XLEN-1:0]  load_data,
	output logic                       retire_valid,
	output logic [core_pkg::XLEN-1:0]  retire_pc,
	output logic [4:0]                 retire_rd,
	output logic [core_pkg::XLEN-1:0]  retire_data,
	output logic                       halted
);
	import core_pkg::*;

	typedef enum logic [2:0] {st_idle, st_fetch, st_exec, st_mem, st_wb, st_halt} state_t;

	state_t          state;
	logic [XLEN-1:0] pc_q, next_pc;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [6:0]      opcode;
	logic            is_load, is_store, is_ecall, writes_rd, br_taken;

	assign opcode   = instr[6:0];
	assign is_load  = (opcode == opc_load);
	assign is_store = (opcode == opc_store);
	assign is_ecall = (opcode == opc_system);
	assign writes_rd = opcode inside {opc_lui, opc_auipc, opc_jal, opc_jalr,
		opc_op, opc_op_imm, opc_load};

	// immediates, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign alu_a = (alu_op == alu_pc_add) ? pc_q : ((opcode == opc_lui) ? '0 : rs1_data);

	always_comb begin
		case (opcode)
			opc_op, opc_branch: alu_b = rs2_data;
			opc_jal, opc_jalr:  alu_b = XLEN'(4); // link value
			opc_lui, opc_auipc: alu_b = imm_u;
			opc_store:          alu_b = imm_s;
			default:            alu_b = imm_i; // op_imm, load, fence, system
		endcase
	end

	// beq/bne on zero flag, the rest on slt/sltu bit 0; funct3[0] inverts
	assign br_taken = instr[14] ? (alu_result[0] ^ instr[12]) : (alu_zero ^ instr[12]);

	always_comb begin
		next_pc = pc_q + XLEN'(4);
		case (opcode)
			opc_jal:    next_pc = pc_q + imm_j;
			opc_jalr:   next_pc = (rs1_data + imm_i) & ~XLEN'(1);
			opc_branch: next_pc = br_taken ? pc_q + imm_b : pc_q + XLEN'(4);
			default:    ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pc_q  <= '0;
		end else begin
			case (state)
				st_idle:  if (run) state <= st_fetch;
				st_fetch: if (fetch_done) state <= st_exec;
				st_exec:  state <= (is_load || is_store) ? st_mem : st_wb;
				st_mem:   if (lsu_done) state <= st_wb;
				st_wb: begin
					pc_q  <= next_pc;
					state <= is_ecall ? st_halt : st_fetch;
				end
				default: ; // halt, wait for reset
			endcase
		end
	end

	// next fetch issued straight out of wb with the new pc
	assign fetch_start = (state == st_idle && run) || (state == st_wb && !is_ecall);
	assign pc          = (state == st_wb) ? next_pc : pc_q;

	assign lsu_start = (state == st_exec) && (is_load || is_store);
	assign lsu_we    = is_store;
	assign lsu_addr  = alu_result; // rs1 + imm
	assign lsu_wdata = rs2_data;

	assign rf_we = (state == st_wb) && writes_rd;
	assign rf_wa = instr[11:7];
	assign rf_wd = is_load ? load_data : alu_result;

	assign retire_valid = (state == st_wb);
	assign retire_pc    = pc_q;
	assign retire_rd    = writes_rd ? instr[11:7] : 5'd0; // stores, branches report x0
	assign retire_data  = (retire_rd == 5'd0) ? '0 : rf_wd;
	assign halted       = (state == st_halt);

	a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
		!(fetch_start && lsu_start));

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int XLEN = 32; // data and address width

	// alu operations, shared by decoder, alu and controller
	typedef enum logic [3:0] {
		alu_none,   // result forced to 0
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pc_add  // a is the pc here
	} alu_op_t;

	// rv32i major opcodes
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_fence  = 7'b0001111;
	localparam logic [6:0] opc_system = 7'b1110011; // ecall only

endpackage

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int MEM_WORDS = 256,
	localparam int AW = $clog2(MEM_WORDS)
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       fetch_start,
	input  logic [core_pkg::XLEN-1:0]  pc,
	output logic                       fetch_req,
	output logic [AW-1:0]              fetch_addr,
	input  logic                       fetch_gnt,
	input  logic                       fetch_rvalid,
	input  logic [core_pkg::XLEN-1:0]  mem_rdata,
	output logic                       fetch_done,
	output logic [core_pkg::XLEN-1:0]  instr
);
	logic wait_rd; // granted, read data pending

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_req  <= 1'b0;
			wait_rd    <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			if (fetch_start) begin
				fetch_req <= 1'b1;
			end else if (fetch_req && fetch_gnt) begin
				fetch_req <= 1'b0; // drop after grant
				wait_rd   <= 1'b1;
			end else if (wait_rd && fetch_rvalid) begin
				wait_rd    <= 1'b0;
				fetch_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_start)
			fetch_addr <= pc[AW+1:2]; // byte pc to word address
		if (wait_rd && fetch_rvalid)
			instr <= mem_rdata; // held until next fetch returns
	end

endmodule

`default_nettype wire

// ==== logic/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu #(
	parameter int MEM_WORDS = 256,
	localparam int AW = $clog2(MEM_WORDS)
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       lsu_start,
	input  logic                       lsu_we,
	input  logic [core_pkg::XLEN-1:0]  lsu_addr,
	input  logic [core_pkg::XLEN-1:0]  lsu_wdata,
	output logic                       ls_req,
	output logic                       ls_we,
	output logic [AW-1:0]              ls_addr,
	output logic [core_pkg::XLEN-1:0]  ls_wdata,
	input  logic                       ls_gnt,
	input  logic                       ls_rvalid,
	input  logic [core_pkg::XLEN-1:0]  mem_rdata,
	output logic                       lsu_done,
	output logic [core_pkg::XLEN-1:0]  load_data
);
	logic wait_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ls_req   <= 1'b0;
			wait_rd  <= 1'b0;
			lsu_done <= 1'b0;
		end else begin
			lsu_done <= 1'b0;
			if (lsu_start) begin
				ls_req <= 1'b1;
			end else if (ls_req && ls_gnt) begin
				ls_req   <= 1'b0;
				wait_rd  <= !ls_we;
				lsu_done <= ls_we; // store completes at grant
			end else if (wait_rd && ls_rvalid) begin
				wait_rd  <= 1'b0;
				lsu_done <= 1'b1;
			end
		end
	end

	// request fields, word aligned only
	always_ff @(posedge clk) begin
		if (lsu_start) begin
			ls_we    <= lsu_we;
			ls_addr  <= lsu_addr[AW+1:2];
			ls_wdata <= lsu_wdata;
		end
		if (wait_rd && ls_rvalid)
			load_data <= mem_rdata;
	end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int MEM_WORDS = 256,
	localparam int AW = $clog2(MEM_WORDS)
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       host_req,   // write only
	input  logic [AW-1:0]              host_addr,
	input  logic [core_pkg::XLEN-1:0]  host_wdata,
	input  logic                       ls_req,
	input  logic                       ls_we,
	input  logic [AW-1:0]              ls_addr,
	input  logic [core_pkg::XLEN-1:0]  ls_wdata,
	output logic                       ls_gnt,
	output logic                       ls_rvalid,
	input  logic                       fetch_req,  // read only
	input  logic [AW-1:0]              fetch_addr,
	output logic                       fetch_gnt,
	output logic                       fetch_rvalid,
	output logic                       mem_en,
	output logic                       mem_we,
	output logic [AW-1:0]              mem_addr,
	output logic [core_pkg::XLEN-1:0]  mem_wdata
);
	// host > lsu > fetch, host always wins
	assign ls_gnt    = ls_req && !host_req;
	assign fetch_gnt = fetch_req && !host_req && !ls_req;

	assign mem_en    = host_req || ls_req || fetch_req;
	assign mem_we    = host_req || (ls_gnt && ls_we);
	assign mem_addr  = host_req ? host_addr : (ls_req ? ls_addr : fetch_addr);
	assign mem_wdata = host_req ? host_wdata : ls_wdata; // fetch never writes

	// remember who read, to steer rvalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ls_rvalid    <= 1'b0;
			fetch_rvalid <= 1'b0;
		end else begin
			ls_rvalid    <= ls_gnt && !ls_we;
			fetch_rvalid <= fetch_gnt;
		end
	end

	a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({host_req, ls_gnt, fetch_gnt}));

	a_rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		(ls_rvalid || fetch_rvalid) |-> $past(mem_en && !mem_we));

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [4:0]                 ra1,
	input  logic [4:0]                 ra2,
	output logic [core_pkg::XLEN-1:0]  rd1,
	output logic [core_pkg::XLEN-1:0]  rd2,
	input  logic                       we,
	input  logic [4:0]                 wa,
	input  logic [core_pkg::XLEN-1:0]  wd
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin // x0 stays zero
			regs[wa] <= wd;
		end
	end

	assign rd1 = regs[ra1]; // async read
	assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// ==== logic/rv_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_subsys_top #(
	parameter int MEM_WORDS = 256,
	localparam int AW = $clog2(MEM_WORDS)
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run,
	input  logic                       host_we,    // one write per cycle
	input  logic [AW-1:0]              host_addr,  // word address
	input  logic [core_pkg::XLEN-1:0]  host_wdata,
	output logic                       retire_valid,
	output logic [core_pkg::XLEN-1:0]  retire_pc,
	output logic [4:0]                 retire_rd,
	output logic [core_pkg::XLEN-1:0]  retire_data,
	output logic                       halted
);
	import core_pkg::*;

	alu_op_t         alu_op;
	logic [XLEN-1:0] instr, pc, alu_a, alu_b, alu_result, rs1_data, rs2_data, rf_wd;
	logic [XLEN-1:0] lsu_addr, lsu_wdata, load_data, ls_wdata, mem_wdata, mem_rdata;
	logic [AW-1:0]   fetch_addr, ls_addr, mem_addr;
	logic [4:0]      rf_wa;
	logic            alu_zero, rf_we, fetch_start, fetch_done, lsu_start, lsu_we, lsu_done;
	logic            fetch_req, fetch_gnt, fetch_rvalid, ls_req, ls_we, ls_gnt, ls_rvalid;
	logic            mem_en, mem_we;

	core_ctrl u_ctrl (
		.clk, .rst_n, .run, .instr, .fetch_done, .fetch_start, .pc,
		.alu_op, .alu_a, .alu_b, .alu_result, .alu_zero, .rs1_data, .rs2_data,
		.rf_we, .rf_wa, .rf_wd, .lsu_start, .lsu_we, .lsu_addr, .lsu_wdata,
		.lsu_done, .load_data, .retire_valid, .retire_pc, .retire_rd,
		.retire_data, .halted
	);

	alu_op_decode u_dec (
		.opcode(instr[6:0]), .funct3(instr[14:12]), .funct7_b5(instr[30]), .alu_op
	);

	alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero));

	// read addresses straight from the held instruction
	regfile u_rf (
		.clk, .rst_n, .ra1(instr[19:15]), .ra2(instr[24:20]), .rd1(rs1_data),
		.rd2(rs2_data), .we(rf_we), .wa(rf_wa), .wd(rf_wd)
	);

	fetch_unit #(.MEM_WORDS(MEM_WORDS)) u_fetch (
		.clk, .rst_n, .fetch_start, .pc, .fetch_req, .fetch_addr, .fetch_gnt,
		.fetch_rvalid, .mem_rdata, .fetch_done, .instr
	);

	lsu #(.MEM_WORDS(MEM_WORDS)) u_lsu (
		.clk, .rst_n, .lsu_start, .lsu_we, .lsu_addr, .lsu_wdata, .ls_req, .ls_we,
		.ls_addr, .ls_wdata, .ls_gnt, .ls_rvalid, .mem_rdata, .lsu_done, .load_data
	);

	mem_arbiter #(.MEM_WORDS(MEM_WORDS)) u_arb (
		.clk, .rst_n, .host_req(host_we), .host_addr, .host_wdata,
		.ls_req, .ls_we, .ls_addr, .ls_wdata, .ls_gnt, .ls_rvalid,
		.fetch_req, .fetch_addr, .fetch_gnt, .fetch_rvalid,
		.mem_en, .mem_we, .mem_addr, .mem_wdata
	);

	word_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
		.clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

endmodule

`default_nettype wire

// ==== logic/word_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_sram #(
	parameter int MEM_WORDS = 256,
	localparam int AW = $clog2(MEM_WORDS)
) (
	input  logic                       clk,
	input  logic                       mem_en,
	input  logic                       mem_we,
	input  logic [AW-1:0]              mem_addr,
	input  logic [core_pkg::XLEN-1:0]  mem_wdata,
	output logic [core_pkg::XLEN-1:0]  mem_rdata
);
	import core_pkg::*;

	logic [XLEN-1:0] mem [MEM_WORDS];

	always_ff @(posedge clk) begin
		if (mem_en) begin
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem[mem_addr]; // one cycle read latency
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/core_pkg.sv
logic/alu_op_decode.sv
logic/alu.sv
logic/regfile.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/mem_arbiter.sv
logic/word_sram.sv
logic/core_ctrl.sv
logic/rv_subsys_top.sv
test/tb_rv_subsys.sv

// ==== test/tb_patterns.txt ====
// first the program word count and the record count, then the program words
// then one record per line with test number, pc, rd and data
2b 23
00500093 ffd00113 002081b3 40110233 // 00 addi x1 5, addi x2 -3, add x3, sub x4
001122b3 00113333 0020c3b3 0020e433 // 10 slt x5, sltu x6, xor x7, or x8
00f17493 00109533 401255b3 00125633 // 20 andi x9, sll x10, sra x11, srl x12
40115693 12345737 00001797 0080086f // 30 srai x13, lui x14, auipc x15, jal x16
00100f93 048088e7 00100f93 00208463 // 40 skip, jalr x17 72(x1), skip, beq x1 x2
00108463 00100f93 00109463 00209463 // 50 beq x1 x1, skip, bne x1 x1, bne x1 x2
00100f93 0020c463 00114463 00100f93 // 60 skip, blt x1 x2, blt x2 x1, skip
00115463 0020d463 00100f93 00116463 // 70 bge x2 x1, bge x1 x2, skip, bltu x2 x1
0020e463 00100f93 0020f463 00117463 // 80 bltu x1 x2, skip, bgeu x1 x2, bgeu x2 x1
00100f93 20000a13 00ea2223 004a2a83 // 90 skip, addi x20 0x200, sw x14, lw x21
00108033 0ff0000f 00000073          // a0 add x0, fence, ecall
1 00000000 01 00000005
1 00000004 02 fffffffd
1 00000008 03 00000002
1 0000000c 04 fffffff8 // sub
1 00000010 05 00000001 // signed -3 < 5
1 00000014 06 00000000 // unsigned compare fails
1 00000018 07 fffffff8
1 0000001c 08 fffffffd
1 00000020 09 0000000d
1 00000024 0a 000000a0
1 00000028 0b ffffffff // sra of a negative value
1 0000002c 0c 07ffffff
1 00000030 0d fffffffe // srai of -3
2 00000034 0e 12345000
2 00000038 0f 00001038
2 0000003c 10 00000040 // jal link
2 00000044 11 00000048 // jalr link, target 0x4c
3 0000004c 00 00000000
3 00000050 00 00000000
3 00000058 00 00000000
3 0000005c 00 00000000
3 00000064 00 00000000
3 00000068 00 00000000
3 00000070 00 00000000
3 00000074 00 00000000
3 0000007c 00 00000000
3 00000080 00 00000000
3 00000088 00 00000000
3 0000008c 00 00000000
4 00000094 14 00000200
4 00000098 00 00000000 // store
4 0000009c 15 12345000 // load of the stored word
5 000000a0 00 00000000 // write to x0
5 000000a4 00 00000000 // fence
6 000000a8 00 00000000 // ecall

// ==== test/tb_rv_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_subsys;

	localparam int MEM_WORDS = 256;
	localparam int AW        = $clog2(MEM_WORDS);
	localparam int PAT_WORDS = 512; // program plus four words per record

	logic          clk;
	logic          rst_n;
	logic          run;
	logic          host_we;
	logic [AW-1:0] host_addr;
	logic [31:0]   host_wdata;
	logic          retire_valid;
	logic [31:0]   retire_pc;
	logic [4:0]    retire_rd;
	logic [31:0]   retire_data;
	logic          halted;

	logic [31:0] pat [PAT_WORDS]; // whole pattern file
	int          n_prog;          // program words
	int          n_rec;           // expected retire records
	int          rec_base;        // index of first record
	int          retired;         // retirements seen so far
	int          cycles;
	int          limit;           // cycle budget for the run
	int          checks;
	int          errors;
	int          cur_test;        // test number of the last record
	int          test_checks [8];
	int          test_errors [8];

	rv_subsys_top #(.MEM_WORDS(MEM_WORDS)) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.host_we      (host_we),
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.halted       (halted)
	);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) cycles <= cycles + 1;

	task automatic compare_word(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		test_checks[cur_test]++;
		if (act !== exp) begin
			$display("[ERROR] time %0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
			test_errors[cur_test]++;
		end
	endtask

	task automatic flag_failure(input string what);
		$display("%s", what);
		errors++;
		test_errors[cur_test]++;
	endtask

	task automatic report_test(input int t);
		$display("test %0d finished with %0d checks and %0d errors", t,
			test_checks[t], test_errors[t]);
	endtask

	// retire outputs are steady mid cycle, sample them on the falling edge
	always @(negedge clk) begin
		int idx;
		if (rst_n && retire_valid) begin
			if (retired >= n_rec) begin
				flag_failure($sformatf("extra retirement at pc %h after the expected trace",
					retire_pc));
			end else begin
				idx = rec_base + 4 * retired;
				if (pat[idx] != cur_test) begin // next test starts here
					if (cur_test != 0)
						report_test(cur_test);
					cur_test = pat[idx];
				end
				compare_word("retire_pc", pat[idx+1], retire_pc);
				compare_word("retire_rd", pat[idx+2], {27'b0, retire_rd});
				compare_word("retire_data", pat[idx+3], retire_data);
			end
			retired++;
		end
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		run        = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		cycles     = 0;
		limit      = 0;
		retired    = 0;
		checks     = 0;
		errors     = 0;
		cur_test   = 0;
		for (int t = 0; t < 8; t++) begin
			test_checks[t] = 0;
			test_errors[t] = 0;
		end

		$readmemh("test/tb_patterns.txt", pat);
		n_prog   = pat[0];
		n_rec    = pat[1];
		rec_base = 2 + n_prog;
		limit    = 40 * n_rec + 200;

		repeat (2) @(negedge clk); // reset for two cycles
		rst_n = 1'b1;

		// host loads the program one word per cycle while run is low
		for (int i = 0; i < n_prog; i++) begin
			@(negedge clk);
			host_we    = 1'b1;
			host_addr  = AW'(i);
			host_wdata = pat[2+i];
		end
		@(negedge clk);
		host_we = 1'b0;
		run     = 1'b1;

		// keep watching after ecall so that stray retirements are caught
		while (cycles < limit)
			@(posedge clk);
		@(negedge clk);

		if (!halted)
			flag_failure("core did not halt before the cycle limit");
		if (retired != n_rec)
			flag_failure($sformatf("core retired %0d instructions, the trace has %0d",
				retired, n_rec));
		report_test(cur_test);
		$display("%0d retired, %0d checks, %0d errors", retired, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
